/* include/board_params.svh */
// --------------------------------------------------------------------------
// Board-wide constants for the motor-controller register block.
// Include wherever the address map, channel count, version word or
// default timings are needed.
// --------------------------------------------------------------------------

`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// ------------------------------------------------------------------------
// address map
// ------------------------------------------------------------------------

// value of address bits 15:12 that selects the main register space
`define ADDR_MAIN 4'h0

// ------------------------------------------------------------------------
// board identity
// ------------------------------------------------------------------------

`define NUM_CHAN 4'd4                     // axes on this board, status[31:28]
`define BOARD_VERSION 32'h514C4131        // ascii "QLA1"

// ------------------------------------------------------------------------
// default timings
// ------------------------------------------------------------------------

// settle count in units of 256 sysclk cycles
// 7680 * 256 / 49.152 MHz is roughly 40 ms
`define MV_SETTLE_DEFAULT 16'd7680

// sysclk cycles per watchdog tick, 256 cycles is about 5.2 us at 49.152 MHz
`define WDOG_TICK_DEFAULT 256

`endif

/* hdl/board_pkg.sv */
// --------------------------------------------------------------------------
// Shared types for the board register block: the host register bus words,
// the main-space register offsets and the watchdog period.
// Import with a wildcard in the module header.
// --------------------------------------------------------------------------

`default_nettype none

package board_pkg;

    typedef logic [15:0] reg_addr_t;     // host register address
    typedef logic [31:0] reg_data_t;     // host register data word

    // offset within the main space, address bits 3:0
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,
        REG_WDOG    = 4'd3,
        REG_VERSION = 4'd4,
        REG_TEMPSNS = 4'd5,
        REG_DIGIOUT = 4'd6,
        REG_DSSTAT  = 4'd7,
        REG_DIGIN   = 4'd10
    } reg_offset_e;

    // watchdog period in ticks, zero disables the watchdog
    typedef logic [15:0] wdog_period_t;

endpackage

`default_nettype wire

/* hdl/host_wdog.sv */
// --------------------------------------------------------------------------
// Host watchdog. Any host register write refreshes it; if the host stays
// quiet for a whole programmed period a sticky timeout is raised, which
// drops motor power until the host issues a power-enable command.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module host_wdog import board_pkg::*; #(
    parameter int tick_cycles = `WDOG_TICK_DEFAULT   // sysclk cycles per tick
) (
    input  wire logic         sysclk,
    input  wire logic         rst,
    input  wire logic         reg_wen,          // any host write refreshes the counters
    input  wire logic         wdog_wen,         // main write to the period register
    input  wire wdog_period_t reg_wdata,        // low half of the write data
    input  wire logic         pwr_enable_cmd,   // clears the timeout
    output wdog_period_t      wdog_period,
    output logic              wdog_timeout
);

    localparam int PW = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;

    logic [PW-1:0] pre_cnt;                     // prescaler
    wdog_period_t  tick_cnt;                    // ticks since last host write
    logic          tick;

    assign tick = (pre_cnt == PW'(tick_cycles - 1));

    // period register
    always_ff @(posedge sysclk) begin
        if (rst)
            wdog_period <= '0;
        else if (wdog_wen)
            wdog_period <= reg_wdata;
    end

    // ------------------------------------------------------------------------
    // prescaler and tick counter
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (rst || reg_wen) begin
            pre_cnt  <= '0;
            tick_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
            if (tick_cnt < wdog_period)
                tick_cnt <= tick_cnt + 16'd1;   // hold once the period is reached
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // sticky timeout where the clear wins
    always_ff @(posedge sysclk) begin
        if (rst || pwr_enable_cmd)
            wdog_timeout <= 1'b0;
        else if ((wdog_period != '0) && (tick_cnt == wdog_period))
            wdog_timeout <= 1'b1;
    end

    // a disabled watchdog never fires and a quiet host precedes every timeout
    a_no_fire_off: assert property (@(posedge sysclk) disable iff (rst)
        $rose(wdog_timeout) |-> ($past(wdog_period) != '0) && !$past(reg_wen, 2));

endmodule

`default_nettype wire

/* hdl/board_regs.sv */
// --------------------------------------------------------------------------
// General board registers of the four-axis motor controller. Decodes host
// writes to the main space, keeps the power and relay controls, raises the
// one-shot config strobes, packs status and digital-input words, returns
// reads, and holds the amps off while motor voltage settles.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module board_regs import board_pkg::*; #(
    parameter logic [15:0] settle = `MV_SETTLE_DEFAULT   // units of 256 clocks
) (
    input  wire logic         sysclk,
    input  wire logic         rst,

    // host register bus
    input  wire reg_addr_t    reg_waddr,
    input  wire reg_data_t    reg_wdata,
    input  wire logic         reg_wen,
    input  wire reg_addr_t    reg_raddr,
    output reg_data_t         reg_rdata,

    // digital output side
    input  wire logic [31:0]  dout,
    input  wire logic         dout_cfg_valid,
    input  wire logic         dout_cfg_bidir,
    input  wire logic         is_quad_dac,     // 0 = four single dacs, 1 = one quad dac
    input  wire logic         ioexp_present,

    // per-axis inputs
    input  wire logic [4:1]   enc_a,
    input  wire logic [4:1]   enc_b,
    input  wire logic [4:1]   enc_i,
    input  wire logic [4:1]   neg_limit,
    input  wire logic [4:1]   pos_limit,
    input  wire logic [4:1]   home,

    // power and safety
    input  wire logic         relay,
    input  wire logic         mv_faultn,       // active low
    input  wire logic         mv_good,
    input  wire logic         v_fault,
    input  wire logic         safety_fb,
    input  wire logic         mv_fb,
    input  wire logic [3:0]   board_id,        // rotary switch
    input  wire reg_data_t    temp_sense,
    input  wire logic [11:0]  reg_status12,    // amplifier feedback bits
    input  wire reg_data_t    ds_status,

    // watchdog link
    input  wire logic         wdog_timeout,
    input  wire wdog_period_t wdog_period,

    // controls
    output logic              pwr_enable,
    output logic              relay_on,
    output logic              dac_test_reset,
    output logic              ioexp_cfg_reset,
    output logic              dout_cfg_reset,
    output logic              mv_amp_disable,
    output logic              pwr_enable_cmd,
    output logic              wdog_wen,
    output reg_data_t         reg_status,
    output reg_data_t         reg_digin
);

    logic        write_main;                   // host write lands in main space
    logic        write_status;
    reg_offset_e wr_off;
    reg_offset_e rd_off;
    logic [23:0] mv_cnt;                       // settle counter with upper 16 bits compared
    logic [2:0]  strobes;

    // ------------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------------

    assign wr_off = reg_offset_e'(reg_waddr[3:0]);
    assign rd_off = reg_offset_e'(reg_raddr[3:0]);

    assign write_main   = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN) &&
                          (reg_waddr[7:4] == 4'd0);
    assign write_status = write_main && (wr_off == REG_STATUS);
    assign wdog_wen     = write_main && (wr_off == REG_WDOG);

    // host asks for power and clears the watchdog timeout
    assign pwr_enable_cmd = write_status & reg_wdata[19] & reg_wdata[18];

    // ------------------------------------------------------------------------
    // status and digital-input words
    // ------------------------------------------------------------------------

    assign reg_status = {
        `NUM_CHAN, board_id,                                   // 31:24
        wdog_timeout, is_quad_dac, dout_cfg_valid, dout_cfg_bidir,
        mv_good, pwr_enable, ~relay, relay_on,
        ~mv_faultn, safety_fb, 1'b0, ioexp_present,
        reg_status12                                           // 11:0 amp feedback
    };

    // dout[31] flags that some dout is driven by the waveform table
    assign reg_digin = {v_fault, 1'b0, dout[31], mv_fb, enc_a, enc_b, enc_i,
                        dout[3:0], neg_limit, pos_limit, home};

    // ------------------------------------------------------------------------
    // control registers
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (rst) begin
            pwr_enable <= 1'b0;
            relay_on   <= 1'b0;
        end else begin
            if (write_status && reg_wdata[17])
                relay_on <= reg_wdata[16];         // bit 17 masks relay
            // a masked power write beats a watchdog timeout
            if (write_status && reg_wdata[19])
                pwr_enable <= reg_wdata[18];
            else if (wdog_timeout)
                pwr_enable <= 1'b0;
        end
    end

    // strobes and read return share the "no main write" condition
    always_ff @(posedge sysclk) begin
        if (rst) begin
            dac_test_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            dout_cfg_reset  <= 1'b0;
            reg_rdata       <= '0;
        end else if (write_main) begin
            if (write_status) begin
                dac_test_reset  <= reg_wdata[22];  // repeat dac test
                ioexp_cfg_reset <= reg_wdata[23];  // redetect io expander
                dout_cfg_reset  <= reg_wdata[24];  // drop dout config
            end
        end else begin
            dac_test_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            dout_cfg_reset  <= 1'b0;
            case (rd_off)
                REG_STATUS:  reg_rdata <= reg_status;
                REG_WDOG:    reg_rdata <= {16'd0, wdog_period};
                REG_VERSION: reg_rdata <= `BOARD_VERSION;
                REG_TEMPSNS: reg_rdata <= temp_sense;
                REG_DIGIOUT: reg_rdata <= dout;
                REG_DSSTAT:  reg_rdata <= ds_status;
                REG_DIGIN:   reg_rdata <= reg_digin;
                default:     reg_rdata <= '0;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // motor voltage settle timer
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (rst) begin
            mv_cnt         <= '0;
            mv_amp_disable <= 1'b1;
        end else if (!mv_good) begin
            mv_cnt         <= '0;                  // restart on every dropout
            mv_amp_disable <= 1'b1;
        end else if (mv_cnt[23:8] < settle) begin
            mv_cnt         <= mv_cnt + 24'd1;
            mv_amp_disable <= 1'b1;
        end else begin
            mv_amp_disable <= 1'b0;                // settled so the amps may run
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    assign strobes = {dout_cfg_reset, ioexp_cfg_reset, dac_test_reset};

    // a strobe only rises right after a status write
    a_strobe_src: assert property (@(posedge sysclk) disable iff (rst)
        |(strobes & ~$past(strobes)) |-> $past(write_status));

    // amps run only while motor voltage is good and the full settle has passed
    a_mv_off: assert property (@(posedge sysclk) disable iff (rst)
        !mv_amp_disable |-> $past(mv_good) && (mv_cnt[23:8] == settle));

endmodule

`default_nettype wire

/* hdl/board_top.sv */
// --------------------------------------------------------------------------
// Top of the board register block. Joins the register file and the host
// watchdog to the board pins and the host register bus.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module board_top import board_pkg::*; #(
    parameter logic [15:0] settle      = `MV_SETTLE_DEFAULT,
    parameter int          tick_cycles = `WDOG_TICK_DEFAULT
) (
    input  wire logic        sysclk,
    input  wire logic        rst,
    input  wire reg_addr_t   reg_waddr,
    input  wire reg_data_t   reg_wdata,
    input  wire logic        reg_wen,
    input  wire reg_addr_t   reg_raddr,
    output reg_data_t        reg_rdata,
    input  wire logic [31:0] dout,
    input  wire logic        dout_cfg_valid,
    input  wire logic        dout_cfg_bidir,
    input  wire logic        is_quad_dac,
    input  wire logic        ioexp_present,
    input  wire logic [4:1]  enc_a,
    input  wire logic [4:1]  enc_b,
    input  wire logic [4:1]  enc_i,
    input  wire logic [4:1]  neg_limit,
    input  wire logic [4:1]  pos_limit,
    input  wire logic [4:1]  home,
    input  wire logic        relay,
    input  wire logic        mv_faultn,
    input  wire logic        mv_good,
    input  wire logic        v_fault,
    input  wire logic        safety_fb,
    input  wire logic        mv_fb,
    input  wire logic [3:0]  board_id,
    input  wire reg_data_t   temp_sense,
    input  wire logic [11:0] reg_status12,
    input  wire reg_data_t   ds_status,
    output logic             pwr_enable,
    output logic             relay_on,
    output logic             dac_test_reset,
    output logic             ioexp_cfg_reset,
    output logic             dout_cfg_reset,
    output logic             mv_amp_disable,
    output logic             pwr_enable_cmd,   // also feeds the watchdog clear
    output reg_data_t        reg_status,
    output reg_data_t        reg_digin
);

    logic         wdog_wen;                    // period write
    logic         wdog_timeout;
    wdog_period_t wdog_period;

    board_regs #(.settle(settle)) regs0 (
        .sysclk, .rst, .reg_waddr, .reg_wdata, .reg_wen, .reg_raddr, .reg_rdata,
        .dout, .dout_cfg_valid, .dout_cfg_bidir, .is_quad_dac, .ioexp_present,
        .enc_a, .enc_b, .enc_i, .neg_limit, .pos_limit, .home,
        .relay, .mv_faultn, .mv_good, .v_fault, .safety_fb, .mv_fb,
        .board_id, .temp_sense, .reg_status12, .ds_status,
        .wdog_timeout, .wdog_period,
        .pwr_enable, .relay_on, .dac_test_reset, .ioexp_cfg_reset, .dout_cfg_reset,
        .mv_amp_disable, .pwr_enable_cmd, .wdog_wen, .reg_status, .reg_digin
    );

    host_wdog #(.tick_cycles(tick_cycles)) wdog0 (
        .sysclk,
        .rst,
        .reg_wen,
        .wdog_wen,
        .reg_wdata      (reg_wdata[15:0]),     // period sits in the low half
        .pwr_enable_cmd,
        .wdog_period,
        .wdog_timeout
    );

endmodule

`default_nettype wire

/* verif/board_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the board register block. Runs random host register traffic
// and random board inputs against a cycle model, then directed watchdog and
// motor-voltage settle phases. Compile with the file list, top is board_tb.
// --------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "board_params.svh"

module board_tb import board_pkg::*; ();

    localparam int           TICK        = 4;            // tick_cycles of the dut
    localparam logic [15:0]  SETTLE      = 16'd1;
    localparam int           RAND_CYCLES = 3000;
    localparam int           PLANNED     = 4000;         // random run plus directed phases
    localparam int           LIMIT       = PLANNED + PLANNED / 2;
    localparam wdog_period_t WD_P        = 16'd3;        // short period for the timeout test

    logic         sysclk, rst, reg_wen;
    reg_addr_t    reg_waddr, reg_raddr;
    reg_data_t    reg_wdata, reg_rdata, temp_sense, ds_status, reg_status, reg_digin;
    logic [31:0]  dout;
    logic         dout_cfg_valid, dout_cfg_bidir, is_quad_dac, ioexp_present;
    logic [4:1]   enc_a, enc_b, enc_i, neg_limit, pos_limit, home;
    logic         relay, mv_faultn, mv_good, v_fault, safety_fb, mv_fb;
    logic [3:0]   board_id;
    logic [11:0]  reg_status12;
    logic         pwr_enable, relay_on, dac_test_reset, ioexp_cfg_reset, dout_cfg_reset;
    logic         mv_amp_disable, pwr_enable_cmd;

    // reference model state
    logic         m_pwr, m_relay, m_timeout, m_amp_dis;
    logic [2:0]   m_strobe;                              // {dout, ioexp, dac}
    reg_data_t    m_rdata;
    wdog_period_t m_period, m_tick;
    int           m_pre;
    logic [23:0]  m_mvcnt;

    int seed, errors, cycles, i, n;

    board_top #(.settle(SETTLE), .tick_cycles(TICK)) dut0 (.*);

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;                     // 4 ns period
    end

    // run limit
    always @(posedge sysclk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycles);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycles);
        end
    endtask

    task automatic check_period(input string name, input wdog_period_t got,
                                input wdog_period_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycles);
        end
    endtask

    // ------------------------------------------------------------------------
    // model
    // ------------------------------------------------------------------------

    function automatic reg_data_t pack_status();
        reg_data_t w;
        w        = '0;                                   // bit 13 stays zero
        w[31:28] = `NUM_CHAN;
        w[27:24] = board_id;
        w[23]    = m_timeout;
        w[22]    = is_quad_dac;
        w[21]    = dout_cfg_valid;
        w[20]    = dout_cfg_bidir;
        w[19]    = mv_good;
        w[18]    = m_pwr;
        w[17]    = ~relay;
        w[16]    = m_relay;
        w[15]    = ~mv_faultn;                           // fault shown active high
        w[14]    = safety_fb;
        w[12]    = ioexp_present;
        w[11:0]  = reg_status12;
        return w;
    endfunction

    function automatic reg_data_t pack_digin();
        reg_data_t w;
        w        = '0;
        w[31]    = v_fault;
        w[29]    = dout[31];
        w[28]    = mv_fb;
        w[27:24] = enc_a;
        w[23:20] = enc_b;
        w[19:16] = enc_i;
        w[15:12] = dout[3:0];
        w[11:8]  = neg_limit;
        w[7:4]   = pos_limit;
        w[3:0]   = home;
        return w;
    endfunction

    function automatic logic main_write();
        return reg_wen && (reg_waddr[15:12] == `ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    endfunction

    function automatic logic status_write();
        return main_write() && (reg_waddr[3:0] == REG_STATUS);
    endfunction

    // next state from the current inputs, old values used throughout
    task automatic model_step();
        logic ws, cmd;
        ws  = status_write();
        cmd = ws && reg_wdata[19] && reg_wdata[18];
        if (main_write()) begin
            if (ws)
                m_strobe = reg_wdata[24:22];
        end else begin
            m_strobe = 3'b000;
            case (reg_offset_e'(reg_raddr[3:0]))
                REG_STATUS:  m_rdata = pack_status();
                REG_WDOG:    m_rdata = {16'h0000, m_period};
                REG_VERSION: m_rdata = `BOARD_VERSION;
                REG_TEMPSNS: m_rdata = temp_sense;
                REG_DIGIOUT: m_rdata = dout;
                REG_DSSTAT:  m_rdata = ds_status;
                REG_DIGIN:   m_rdata = pack_digin();
                default:     m_rdata = '0;
            endcase
        end
        if (ws && reg_wdata[17])
            m_relay = reg_wdata[16];
        if (ws && reg_wdata[19])
            m_pwr = reg_wdata[18];
        else if (m_timeout)
            m_pwr = 1'b0;
        if (cmd)
            m_timeout = 1'b0;
        else if ((m_period != 16'd0) && (m_tick == m_period))
            m_timeout = 1'b1;
        if (reg_wen) begin                               // any host write refreshes
            m_pre  = 0;
            m_tick = 16'd0;
        end else if (m_pre == TICK - 1) begin
            m_pre = 0;
            if (m_tick < m_period)
                m_tick = m_tick + 16'd1;
        end else begin
            m_pre = m_pre + 1;
        end
        if (main_write() && (reg_waddr[3:0] == REG_WDOG))
            m_period = reg_wdata[15:0];
        if (!mv_good) begin
            m_mvcnt   = 24'd0;
            m_amp_dis = 1'b1;
        end else if (m_mvcnt[23:8] < SETTLE) begin
            m_mvcnt   = m_mvcnt + 24'd1;
            m_amp_dis = 1'b1;
        end else begin
            m_amp_dis = 1'b0;
        end
    endtask

    task automatic check_all();
        check_data("reg_rdata", reg_rdata, m_rdata);
        check_data("reg_status", reg_status, pack_status());
        check_data("reg_digin", reg_digin, pack_digin());
        check_bit("pwr_enable", pwr_enable, m_pwr);
        check_bit("relay_on", relay_on, m_relay);
        check_bit("dac_test_reset", dac_test_reset, m_strobe[0]);
        check_bit("ioexp_cfg_reset", ioexp_cfg_reset, m_strobe[1]);
        check_bit("dout_cfg_reset", dout_cfg_reset, m_strobe[2]);
        check_bit("mv_amp_disable", mv_amp_disable, m_amp_dis);
        check_bit("pwr_enable_cmd", pwr_enable_cmd,
                  status_write() && reg_wdata[19] && reg_wdata[18]);
        check_period("wdog_period", dut0.wdog_period, m_period);
    endtask

    // check mid-cycle, advance the model, then move to the next drive point
    task automatic step();
        #1;
        check_all();
        model_step();
        @(posedge sysclk);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic drive_board(input logic hold_mv);
        reg_data_t r;
        dout = $random(seed);
        r = $random(seed);
        dout_cfg_valid = r[0];
        dout_cfg_bidir = r[1];
        is_quad_dac    = r[2];
        ioexp_present  = r[3];
        relay          = r[4];
        mv_faultn      = r[5];
        v_fault        = r[6];
        safety_fb      = r[7];
        mv_fb          = r[8];
        board_id       = r[12:9];
        reg_status12   = r[24:13];
        if (!hold_mv && (r[31:27] == 5'd0))
            mv_good = ~mv_good;                          // occasional supply change
        r = $random(seed);
        enc_a     = r[3:0];
        enc_b     = r[7:4];
        enc_i     = r[11:8];
        neg_limit = r[15:12];
        pos_limit = r[19:16];
        home      = r[23:20];
        temp_sense = $random(seed);
        ds_status  = $random(seed);
        r = $random(seed);
        reg_raddr = r[15:0];                             // reads roam all offsets
    endtask

    task automatic bus_write(input reg_addr_t a, input reg_data_t d);
        reg_wen   = 1'b1;
        reg_waddr = a;
        reg_wdata = d;
    endtask

    task automatic bus_idle();
        reg_data_t r;
        r = $random(seed);
        reg_wen   = 1'b0;
        reg_waddr = r[15:0];                             // ignored without reg_wen
        reg_wdata = $random(seed);
    endtask

    task automatic random_bus();
        reg_data_t r, d;
        reg_addr_t a;
        r = $random(seed);
        d = $random(seed);
        case (r[2:0])
            3'd0, 3'd1: bus_write({`ADDR_MAIN, r[11:8], 4'h0, 4'(REG_STATUS)}, d);
            3'd2: bus_write({`ADDR_MAIN, r[11:8], 4'h0, 4'(REG_WDOG)},
                            {d[31:16], 13'd0, d[2:0]});   // small periods
            3'd3: begin                                  // outside main space
                a = d[15:0];
                if (r[3])
                    a[7:4] = r[7:4] | 4'h1;
                else
                    a[15:12] = ~`ADDR_MAIN;
                bus_write(a, $random(seed));
            end
            3'd4: bus_write({`ADDR_MAIN, r[11:8], 4'h0, r[15:12]}, d);
            default: bus_idle();
        endcase
    endtask

    task automatic wdog_addr_write(input reg_data_t d);
        bus_write({`ADDR_MAIN, 8'h00, 4'(REG_WDOG)}, d);
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        seed = 32'h1770dfe7;
        errors = 0;
        cycles = 0;
        rst = 1'b1;
        reg_wen = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        dout = '0;
        {dout_cfg_valid, dout_cfg_bidir, is_quad_dac, ioexp_present} = 4'b0000;
        {enc_a, enc_b, enc_i, neg_limit, pos_limit, home} = '0;
        {relay, mv_faultn, mv_good, v_fault, safety_fb, mv_fb} = 6'b010000;
        board_id = 4'h0;
        temp_sense = '0;
        reg_status12 = '0;
        ds_status = '0;
        {m_pwr, m_relay, m_timeout, m_strobe} = '0;      // reset image of the dut
        m_amp_dis = 1'b1;
        m_rdata = '0;
        m_period = '0;
        m_tick = '0;
        m_pre = 0;
        m_mvcnt = '0;
        repeat (3) @(posedge sysclk);
        #1;
        rst = 1'b0;

        for (i = 0; i < RAND_CYCLES; i++) begin
            drive_board(1'b0);
            random_bus();
            step();
        end

        // watchdog: clear, short period, then a quiet host
        drive_board(1'b1);
        bus_write({`ADDR_MAIN, 8'h00, 4'(REG_STATUS)}, 32'h000C_0000);
        step();
        drive_board(1'b1);
        wdog_addr_write({16'h0000, WD_P});
        step();
        n = 1;
        while (!reg_status[23] && (n < 200)) begin
            drive_board(1'b1);
            bus_idle();
            step();
            n++;
        end
        check_data("wdog_timeout_cycles", reg_data_t'(n), reg_data_t'(int'(WD_P) * TICK + 2));
        repeat (4) begin
            drive_board(1'b1);
            bus_idle();
            step();
        end
        check_bit("pwr_enable", pwr_enable, 1'b0);
        drive_board(1'b1);
        bus_write({`ADDR_MAIN, 8'h00, 4'(REG_STATUS)}, 32'h000C_0000);
        step();
        drive_board(1'b1);
        bus_idle();
        step();
        check_bit("wdog_timeout", reg_status[23], 1'b0);
        check_bit("pwr_enable", pwr_enable, 1'b1);

        // zero period disables the watchdog
        drive_board(1'b1);
        wdog_addr_write(32'h0000_0000);
        step();
        repeat (80) begin
            drive_board(1'b1);
            bus_idle();
            step();
        end
        check_bit("wdog_timeout", reg_status[23], 1'b0);

        // settle timer
        mv_good = 1'b0;
        repeat (3) begin
            drive_board(1'b1);
            bus_idle();
            step();
        end
        mv_good = 1'b1;
        n = 0;
        do begin
            drive_board(1'b1);
            bus_idle();
            step();
            n++;
        end while (mv_amp_disable && (n < 400));
        check_data("settle_cycles", reg_data_t'(n), reg_data_t'(int'(SETTLE) * 256 + 1));
        mv_good = 1'b0;
        drive_board(1'b1);
        bus_idle();
        step();
        check_bit("mv_amp_disable", mv_amp_disable, 1'b1);

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
hdl/board_pkg.sv
hdl/host_wdog.sv
hdl/board_regs.sv
hdl/board_top.sv
verif/board_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = board_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
